// ==== design/llc_geom_pkg.sv ====
/* LLC geometry package.
   Line address split into set and tag, and the outcome credit depth. */
`default_nettype none

package llc_geom_pkg;

    // Set index bits; the set is the low part of a line address.
    localparam int set_bits = 4;
    localparam int tag_bits = 8;
    localparam int line_addr_bits = set_bits + tag_bits;

    localparam int num_sets = 1 << set_bits;

    // Outcome credits granted by the receiver after reset.
    localparam int credits = 4;
    localparam int credit_cnt_bits = 3;

    typedef logic [line_addr_bits-1:0] line_addr_t;
    typedef logic [set_bits-1:0] llc_set_t;
    typedef logic [tag_bits-1:0] llc_tag_t;

endpackage

`default_nettype wire

// ==== design/llc_msg_pkg.sv ====
/* LLC message package.
   Kinds of decoded items and the reset walk state. */
`default_nettype none

package llc_msg_pkg;

    // One kind per inbound channel.
    typedef enum logic [1:0] {
        kind_rst,
        kind_rsp,
        kind_req,
        kind_dma
    } item_kind_t;

    // Reset walk over all sets.
    typedef enum logic {
        walk_idle,
        walk_busy
    } walk_state_t;

endpackage

`default_nettype wire

// ==== design/llc_lookup_if.sv ====
/* Lookup path between the input decoder and the tag store. */
`timescale 1ns/1ps
`default_nettype none

interface llc_lookup_if;

    // Registered item from the decoder.
    logic                     valid;
    llc_msg_pkg::item_kind_t  kind;
    llc_geom_pkg::llc_set_t   set;
    llc_geom_pkg::llc_tag_t   tag;
    logic                     take;

    // Flow control and request results from the store.
    logic                     credit_ok;
    logic                     req_done;
    logic                     req_miss;

    modport decoder (
        output valid, kind, set, tag, take,
        input  credit_ok, req_done, req_miss
    );

    modport store (
        input  valid, kind, set, tag, take,
        output credit_ok, req_done, req_miss
    );

endinterface

`default_nettype wire

// ==== design/llc_input_decoder.sv ====
/* LLC input decoder.
   Fixed priority pick among the channels, reset walk, request stall and replay. */
`timescale 1ns/1ps
`default_nettype none

module llc_input_decoder (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     rst_cmd_valid,
    input  wire logic                     rsp_valid,
    input  wire logic                     req_valid,
    input  wire logic                     dma_valid,
    input  wire llc_geom_pkg::line_addr_t rsp_addr,
    input  wire llc_geom_pkg::line_addr_t req_addr,
    input  wire llc_geom_pkg::line_addr_t dma_addr,
    output logic                          rst_cmd_get,
    output logic                          rsp_get,
    output logic                          req_get,
    output logic                          dma_get,
    output logic                          idle,
    llc_lookup_if.decoder                 lk
);

    llc_msg_pkg::walk_state_t walk_state;
    llc_geom_pkg::llc_set_t   walk_set;
    llc_geom_pkg::line_addr_t walk_addr;

    // Request tracking.
    logic                     req_pending;
    logic                     stall;
    logic                     replay;
    logic                     fill_seen;
    llc_geom_pkg::line_addr_t hold_addr;

    logic                     dec_take;
    logic                     replay_take;
    logic                     rsp_hit_hold;
    llc_msg_pkg::item_kind_t  sel_kind;
    llc_geom_pkg::line_addr_t sel_addr;

    assign walk_addr = {llc_geom_pkg::llc_tag_t'(0), walk_set};

    always_comb begin
        rst_cmd_get = 1'b0;
        rsp_get = 1'b0;
        req_get = 1'b0;
        dma_get = 1'b0;
        dec_take = 1'b0;
        replay_take = 1'b0;
        sel_kind = llc_msg_pkg::kind_rst;
        sel_addr = walk_addr;
        if (lk.credit_ok) begin
            if (walk_state == llc_msg_pkg::walk_busy) begin
                dec_take = 1'b1;
            end else if (rsp_valid) begin
                rsp_get = 1'b1;
                dec_take = 1'b1;
                sel_kind = llc_msg_pkg::kind_rsp;
                sel_addr = rsp_addr;
            end else if (replay) begin
                replay_take = 1'b1;
                dec_take = 1'b1;
                sel_kind = llc_msg_pkg::kind_req;
                sel_addr = hold_addr;
            end else if (!stall && !req_pending) begin
                if (req_valid) begin
                    req_get = 1'b1;
                    dec_take = 1'b1;
                    sel_kind = llc_msg_pkg::kind_req;
                    sel_addr = req_addr;
                end else if (dma_valid) begin
                    dma_get = 1'b1;
                    dec_take = 1'b1;
                    sel_kind = llc_msg_pkg::kind_dma;
                    sel_addr = dma_addr;
                end else if (rst_cmd_valid) begin
                    // The command cycle itself decodes set 0.
                    rst_cmd_get = 1'b1;
                    dec_take = 1'b1;
                end
            end
        end
    end

    // A fill for the held address, either before or after the miss is reported.
    assign rsp_hit_hold = rsp_get && (rsp_addr == hold_addr) && (stall || req_pending);

    assign lk.take = dec_take;
    assign idle = !dec_take && (walk_state == llc_msg_pkg::walk_idle) && !stall;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            walk_state <= llc_msg_pkg::walk_idle;
            walk_set <= '0;
        end else if (dec_take && sel_kind == llc_msg_pkg::kind_rst) begin
            walk_set <= walk_set + 1'b1;
            if (rst_cmd_get) begin
                walk_state <= llc_msg_pkg::walk_busy;
            end else if (walk_set == llc_geom_pkg::llc_set_t'(llc_geom_pkg::num_sets - 1)) begin
                walk_state <= llc_msg_pkg::walk_idle;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_pending <= 1'b0;
            stall <= 1'b0;
            replay <= 1'b0;
            fill_seen <= 1'b0;
        end else begin
            if (lk.req_done) begin
                req_pending <= 1'b0;
                fill_seen <= 1'b0;
                if (lk.req_miss) begin
                    if (fill_seen || rsp_hit_hold) begin
                        replay <= 1'b1;
                    end else begin
                        stall <= 1'b1;
                    end
                end
            end else if (rsp_hit_hold) begin
                if (stall) begin
                    stall <= 1'b0;
                    replay <= 1'b1;
                end else begin
                    fill_seen <= 1'b1;
                end
            end
            if (req_get || replay_take) begin
                req_pending <= 1'b1;
                replay <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_get) begin
            hold_addr <= req_addr;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lk.valid <= 1'b0;
        end else begin
            lk.valid <= dec_take;
        end
    end

    // Registered set/tag breakdown.
    always_ff @(posedge clk) begin
        if (dec_take) begin
            lk.kind <= sel_kind;
            lk.set <= sel_addr[llc_geom_pkg::set_bits-1:0];
            lk.tag <= sel_addr[llc_geom_pkg::line_addr_bits-1:llc_geom_pkg::set_bits];
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        $onehot0({rst_cmd_get, rsp_get, req_get, dma_get}));

    assert property (@(posedge clk) disable iff (!rst) lk.take |-> lk.credit_ok);

endmodule

`default_nettype wire

// ==== design/llc_tag_store.sv ====
/* LLC tag store.
   Direct-mapped tags and valid bits, outcome register and credit counter. */
`timescale 1ns/1ps
`default_nettype none

module llc_tag_store (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     out_credit,
    llc_lookup_if.store                   lk,
    output logic                          out_valid,
    output logic                          out_hit,
    output llc_msg_pkg::item_kind_t       out_kind,
    output llc_geom_pkg::llc_set_t        out_set,
    output llc_geom_pkg::llc_tag_t        out_tag
);

    llc_geom_pkg::llc_tag_t                     tag_mem [llc_geom_pkg::num_sets];
    logic [llc_geom_pkg::num_sets-1:0]          valid_bits;
    logic [llc_geom_pkg::credit_cnt_bits-1:0]   credit_cnt;
    logic                                       hit;

    // Hit sees the array before this item's update.
    assign hit = valid_bits[lk.set] && (tag_mem[lk.set] == lk.tag);

    assign lk.credit_ok = (credit_cnt != '0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
        end else if (lk.valid) begin
            if (lk.kind == llc_msg_pkg::kind_rst) begin
                valid_bits[lk.set] <= 1'b0;
            end else if (lk.kind == llc_msg_pkg::kind_rsp) begin
                valid_bits[lk.set] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.valid && lk.kind == llc_msg_pkg::kind_rsp) begin
            tag_mem[lk.set] <= lk.tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
            lk.req_done <= 1'b0;
        end else begin
            out_valid <= lk.valid;
            lk.req_done <= lk.valid && (lk.kind == llc_msg_pkg::kind_req);
        end
    end

    always_ff @(posedge clk) begin
        if (lk.valid) begin
            out_kind <= lk.kind;
            out_set <= lk.set;
            out_tag <= lk.tag;
            out_hit <= hit;
            lk.req_miss <= !hit;
        end
    end

    // One credit spent per decoded item, one returned per out_credit pulse.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            credit_cnt <= llc_geom_pkg::credit_cnt_bits'(llc_geom_pkg::credits);
        end else begin
            case ({lk.take, out_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        credit_cnt <= llc_geom_pkg::credit_cnt_bits'(llc_geom_pkg::credits));

endmodule

`default_nettype wire

// ==== design/llc_frontend_top.sv ====
/* LLC front end.
   Input decoder and tag store joined by the lookup path. */
`timescale 1ns/1ps
`default_nettype none

module llc_frontend_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     rst_cmd_valid,
    input  wire logic                     rsp_valid,
    input  wire llc_geom_pkg::line_addr_t rsp_addr,
    input  wire logic                     req_valid,
    input  wire llc_geom_pkg::line_addr_t req_addr,
    input  wire logic                     dma_valid,
    input  wire llc_geom_pkg::line_addr_t dma_addr,
    input  wire logic                     out_credit,
    output logic                          rst_cmd_get,
    output logic                          rsp_get,
    output logic                          req_get,
    output logic                          dma_get,
    output logic                          out_valid,
    output llc_msg_pkg::item_kind_t       out_kind,
    output llc_geom_pkg::llc_set_t        out_set,
    output llc_geom_pkg::llc_tag_t        out_tag,
    output logic                          out_hit,
    output logic                          idle
);

    llc_lookup_if lk_i ();

    llc_input_decoder llc_input_decoder_i (
        .clk           (clk),
        .rst           (rst),
        .rst_cmd_valid (rst_cmd_valid),
        .rsp_valid     (rsp_valid),
        .req_valid     (req_valid),
        .dma_valid     (dma_valid),
        .rsp_addr      (rsp_addr),
        .req_addr      (req_addr),
        .dma_addr      (dma_addr),
        .rst_cmd_get   (rst_cmd_get),
        .rsp_get       (rsp_get),
        .req_get       (req_get),
        .dma_get       (dma_get),
        .idle          (idle),
        .lk            (lk_i.decoder)
    );

    llc_tag_store llc_tag_store_i (
        .clk        (clk),
        .rst        (rst),
        .out_credit (out_credit),
        .lk         (lk_i.store),
        .out_valid  (out_valid),
        .out_hit    (out_hit),
        .out_kind   (out_kind),
        .out_set    (out_set),
        .out_tag    (out_tag)
    );

endmodule

`default_nettype wire

// ==== verification/llc_frontend_tb.sv ====
/* LLC front end testbench.
   Reference tag model and per-cycle decode prediction, with random channel traffic. */
`timescale 1ns/1ps
`default_nettype none

module llc_frontend_tb;

    localparam int n_iter = 150;
    localparam int cycle_limit = n_iter * 120 + 2000;

    typedef struct packed {
        llc_msg_pkg::item_kind_t kind;
        llc_geom_pkg::llc_set_t  set;
        llc_geom_pkg::llc_tag_t  tag;
        logic                    hit;
        int                      due;
    } exp_t;

    logic clk = 1'b0;
    logic rst, rst_cmd_valid, rsp_valid, req_valid, dma_valid, out_credit;
    llc_geom_pkg::line_addr_t rsp_addr, req_addr, dma_addr;
    logic rst_cmd_get, rsp_get, req_get, dma_get, out_valid, out_hit, idle;
    llc_msg_pkg::item_kind_t out_kind;
    llc_geom_pkg::llc_set_t  out_set;
    llc_geom_pkg::llc_tag_t  out_tag;

    // Reference model state.
    exp_t exp_q[$];
    llc_geom_pkg::line_addr_t rsp_q[$], req_q[$], dma_q[$], m_hold;
    llc_geom_pkg::llc_tag_t m_tag [llc_geom_pkg::num_sets];
    logic [llc_geom_pkg::num_sets-1:0] m_vld = '0;
    logic m_stall = 0, m_pending = 0, m_replay = 0, m_fill = 0;
    logic rst_got = 0, rsp_got = 0, req_got = 0, dma_got = 0;
    int m_walk = 0, m_credits = llc_geom_pkg::credits, rst_left = 0;
    int cyc = 0, outs = 0, returned = 0, hold_cnt = 0;
    logic [31:0] rng = 32'h8ed8;

    llc_frontend_top llc_frontend_top_i (.*);

    always #10 clk = !clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_eq(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        exp_t e;
        logic done, miss, take, p_walk, p_rsp, p_rep, p_req, p_dma, p_rst, rsp_match;
        llc_geom_pkg::line_addr_t a;
        if (rst) begin
            cyc++;
            done = 1'b0;
            miss = 1'b0;
            if (out_valid) begin
                outs++;
                assert (outs <= llc_geom_pkg::credits + returned) else begin
                    $display("Outcome count went beyond the credits granted");
                    $display("test failed");
                    $fatal(1);
                end
            end
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                check_eq("out_valid", 1, out_valid);
                check_eq("out_kind", e.kind, out_kind);
                check_eq("out_set", e.set, out_set);
                check_eq("out_tag", e.tag, out_tag);
                check_eq("out_hit", e.hit, out_hit);
                done = (e.kind == llc_msg_pkg::kind_req);
                miss = !e.hit;
            end else begin
                check_eq("out_valid", 0, out_valid);
            end
            {p_walk, p_rsp, p_rep, p_req, p_dma, p_rst} = '0;
            if (m_credits > 0) begin
                if (m_walk > 0) p_walk = 1'b1;
                else if (rsp_valid) p_rsp = 1'b1;
                else if (m_replay) p_rep = 1'b1;
                else if (!m_stall && !m_pending) begin
                    if (req_valid) p_req = 1'b1;
                    else if (dma_valid) p_dma = 1'b1;
                    else if (rst_cmd_valid) p_rst = 1'b1;
                end
            end
            take = p_walk | p_rsp | p_rep | p_req | p_dma | p_rst;
            check_eq("rst_cmd_get", p_rst, rst_cmd_get);
            check_eq("rsp_get", p_rsp, rsp_get);
            check_eq("req_get", p_req, req_get);
            check_eq("dma_get", p_dma, dma_get);
            check_eq("idle", !take && m_walk == 0 && !m_stall, idle);
            rsp_match = p_rsp && rsp_addr == m_hold && (m_stall || m_pending);
            // Miss result of a request arrives with its outcome.
            if (done) begin
                m_pending = 1'b0;
                if (miss) begin
                    if (m_fill || rsp_match) m_replay = 1'b1;
                    else m_stall = 1'b1;
                end
                m_fill = 1'b0;
            end else if (rsp_match) begin
                if (m_stall) begin
                    m_stall = 1'b0;
                    m_replay = 1'b1;
                end else m_fill = 1'b1;
            end
            if (take) begin
                e.kind = llc_msg_pkg::kind_rst;
                a = llc_geom_pkg::line_addr_t'(p_walk ? 16 - m_walk : 0);
                if (p_rsp) begin
                    e.kind = llc_msg_pkg::kind_rsp;
                    a = rsp_addr;
                end else if (p_rep || p_req) begin
                    e.kind = llc_msg_pkg::kind_req;
                    a = p_req ? req_addr : m_hold;
                end else if (p_dma) begin
                    e.kind = llc_msg_pkg::kind_dma;
                    a = dma_addr;
                end
                e.set = a[llc_geom_pkg::set_bits-1:0];
                e.tag = a[llc_geom_pkg::line_addr_bits-1:llc_geom_pkg::set_bits];
                e.hit = m_vld[e.set] && m_tag[e.set] == e.tag;
                e.due = cyc + 2;
                exp_q.push_back(e);
                if (e.kind == llc_msg_pkg::kind_rst) m_vld[e.set] = 1'b0;
                if (e.kind == llc_msg_pkg::kind_rsp) begin
                    m_vld[e.set] = 1'b1;
                    m_tag[e.set] = e.tag;
                end
                if (p_walk) m_walk--;
                if (p_rst) m_walk = llc_geom_pkg::num_sets - 1;
                if (p_req) m_hold = req_addr;
                if (p_req || p_rep) begin
                    m_pending = 1'b1;
                    m_replay = 1'b0;
                end
            end
            m_credits = m_credits - int'(take) + int'(out_credit);
            returned += int'(out_credit);
            {rst_got, rsp_got, req_got, dma_got} = {rst_cmd_get, rsp_get, req_get, dma_get};
            if (cyc > cycle_limit) begin
                $display("Timeout, the run did not finish within the cycle limit");
                $display("test failed");
                $fatal(1);
            end
        end
    end

    // Channel sources and the credit receiver.
    always @(negedge clk) begin
        if (rst_got) rst_cmd_valid = 1'b0;
        if (!rst_cmd_valid && rst_left > 0) begin
            rst_cmd_valid = 1'b1;
            rst_left--;
        end
        if (rsp_got) rsp_valid = 1'b0;
        if (!rsp_valid && rsp_q.size() > 0) {rsp_valid, rsp_addr} = {1'b1, rsp_q.pop_front()};
        if (req_got) req_valid = 1'b0;
        if (!req_valid && req_q.size() > 0) {req_valid, req_addr} = {1'b1, req_q.pop_front()};
        if (dma_got) dma_valid = 1'b0;
        if (!dma_valid && dma_q.size() > 0) {dma_valid, dma_addr} = {1'b1, dma_q.pop_front()};
        rng = xorshift32(rng);
        if (hold_cnt > 0) begin
            hold_cnt--;
            out_credit = 1'b0;
        end else if (rng[5:0] == 0) begin
            hold_cnt = 40;
            out_credit = 1'b0;
        end else begin
            out_credit = (outs > returned) && rng[9:8] != 0;
        end
    end

    task automatic drain();
        while (rsp_q.size() > 0 || req_q.size() > 0 || dma_q.size() > 0 || rst_left > 0 ||
               rst_cmd_valid || rsp_valid || req_valid || dma_valid || m_stall ||
               m_pending || m_replay || m_walk > 0 || exp_q.size() > 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        llc_geom_pkg::line_addr_t a;
        {rst, rst_cmd_valid, rsp_valid, req_valid, dma_valid, out_credit} = '0;
        {rsp_addr, req_addr, dma_addr} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk) rst = 1'b1;
        // Walk, then a missing request stalls the DMA behind it.
        rst_left = 1;
        while (m_walk == 0) @(posedge clk);
        req_q.push_back(12'h3a5);
        dma_q.push_back(12'h3a5);
        while (!m_stall) @(posedge clk);
        rsp_q.push_back(12'h4a5);
        repeat (12) @(posedge clk);
        rsp_q.push_back(12'h3a5);
        drain();
        @(negedge clk);
        rsp_q.push_back(12'h17c);
        req_q.push_back(12'h17c);
        drain();
        for (int i = 0; i < n_iter; i++) begin
            rng = xorshift32(rng);
            a = {6'b0, rng[21:20], rng[19:16]};
            case (rng[1:0])
                2'd0: rsp_q.push_back(a);
                2'd1: begin
                    rsp_q.push_back(a);
                    req_q.push_back(a);
                end
                2'd2: begin
                    req_q.push_back(a);
                    while (!m_stall && (req_q.size() > 0 || req_valid || m_pending))
                        @(posedge clk);
                    if (m_stall) rsp_q.push_back(a);
                end
                default: dma_q.push_back(a);
            endcase
            if (rng[12:8] == 0) rst_left++;
            drain();
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/llc_geom_pkg.sv
design/llc_msg_pkg.sv
design/llc_lookup_if.sv
design/llc_input_decoder.sv
design/llc_tag_store.sv
design/llc_frontend_top.sv
verification/llc_frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LLC front end simulation with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module llc_frontend_tb \
    -f files.f \
    --Mdir obj_dir -o llc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/llc_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
